//--- cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes

    localparam int WORD_W    = 16;
    localparam int REG_W     = 3;
    localparam int NUM_REGS  = 8;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;

    //////////////////////////////////////////////////
    // Instruction fields

    localparam int OP_W   = 4;
    localparam int OP_LSB = 12;
    localparam int RD_LSB = 9;
    localparam int RS_LSB = 6;
    localparam int RT_LSB = 3;
    localparam int IMM6_W = 6;
    localparam int IMM8_W = 8;
    localparam int OFF9_W = 9;

    // All-zero word decodes as OP_NOP
    localparam logic [WORD_W-1:0] NOP_WORD = '0;

    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_SLT  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LI   = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9,
        OP_BEQZ = 4'd10,
        OP_BNEZ = 4'd11,
        OP_B    = 4'd12
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_SLT   = 3'd4,
        ALU_PASSB = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_EQZ    = 2'd1,
        BR_NEZ    = 2'd2,
        BR_ALWAYS = 2'd3
    } br_kind_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_t;

endpackage

//--- fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [WORD_W-1:0] prog_data,
    input  logic              stall,
    input  logic              flush,
    input  logic              branch_taken,
    input  logic [ADDR_W-1:0] branch_target,
    output logic [ADDR_W-1:0] pc_id,
    output logic [WORD_W-1:0] instr_id
);

    logic [WORD_W-1:0] imem [MEM_DEPTH];
    logic [ADDR_W-1:0] pc;
    logic [WORD_W-1:0] instr;

    // Program load port
    always_ff @(posedge clk)
    begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
    end

    assign instr = imem[pc];

    // Redirect beats stall
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (branch_taken)
            pc <= branch_target;
        else if (!stall)
            pc <= pc + 1'b1;
    end

    //////////////////////////////////////////////////
    // IF/ID

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            pc_id    <= '0;
            instr_id <= NOP_WORD;
        end
        else if (!stall)
        begin
            pc_id    <= pc;
            instr_id <= instr;
        end
    end

endmodule

//--- decode_stage.sv
module decode_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] pc_id,
    input  logic [WORD_W-1:0] instr_id,
    input  logic              stall,
    input  logic              flush,
    input  logic              wb_en,
    input  logic [REG_W-1:0]  wb_reg,
    input  logic [WORD_W-1:0] wb_data,
    output logic [REG_W-1:0]  rs_idx,
    output logic [REG_W-1:0]  rt_idx,
    output logic [REG_W-1:0]  rd_idx,
    output logic [ADDR_W-1:0] pc_ex,
    output logic [WORD_W-1:0] rs_val_ex,
    output logic [WORD_W-1:0] rt_val_ex,
    output logic [WORD_W-1:0] rd_val_ex,
    output logic [REG_W-1:0]  rs_ex,
    output logic [REG_W-1:0]  rt_ex,
    output logic [REG_W-1:0]  rd_ex,
    output logic [WORD_W-1:0] imm_ex,
    output alu_op_t           alu_op_ex,
    output br_kind_t          br_kind_ex,
    output logic              mem_read_ex,
    output logic              mem_write_ex,
    output logic              reg_write_ex,
    output logic              use_imm_ex
);

    logic [WORD_W-1:0] regs [NUM_REGS];
    opcode_t           op;
    alu_op_t           alu_op;
    br_kind_t          br_kind;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              use_imm;
    logic [WORD_W-1:0] imm;
    logic [WORD_W-1:0] rs_val;
    logic [WORD_W-1:0] rt_val;
    logic [WORD_W-1:0] rd_val;

    assign op     = opcode_t'(instr_id[OP_LSB +: OP_W]);
    assign rd_idx = instr_id[RD_LSB +: REG_W];
    assign rs_idx = instr_id[RS_LSB +: REG_W];
    assign rt_idx = instr_id[RT_LSB +: REG_W];

    //////////////////////////////////////////////////
    // Control decode

    always_comb
    begin
        alu_op    = ALU_ADD;
        br_kind   = BR_NONE;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        use_imm   = 1'b0;
        // Sign-extended imm6 unless the opcode says otherwise
        imm = {{(WORD_W-IMM6_W){instr_id[IMM6_W-1]}}, instr_id[IMM6_W-1:0]};
        case (op)
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_OR,
            OP_SLT:
            begin
                reg_write = 1'b1;
                case (op)
                    OP_SUB:  alu_op = ALU_SUB;
                    OP_AND:  alu_op = ALU_AND;
                    OP_OR:   alu_op = ALU_OR;
                    OP_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ADDI:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            OP_LI:
            begin
                alu_op    = ALU_PASSB;
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = {{(WORD_W-IMM8_W){1'b0}}, instr_id[IMM8_W-1:0]};
            end
            OP_LW:
            begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            OP_SW:
            begin
                mem_write = 1'b1;
                use_imm   = 1'b1;
            end
            OP_BEQZ,
            OP_BNEZ,
            OP_B:
            begin
                if (op == OP_BEQZ)
                    br_kind = BR_EQZ;
                else if (op == OP_BNEZ)
                    br_kind = BR_NEZ;
                else
                    br_kind = BR_ALWAYS;
                imm = {{(WORD_W-OFF9_W){instr_id[OFF9_W-1]}}, instr_id[OFF9_W-1:0]};
            end
            default:
            begin
                reg_write = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Register file, writeback passed straight to the reads

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
            regs[wb_reg] <= wb_data;
    end

    assign rs_val = (wb_en && wb_reg == rs_idx) ? wb_data : regs[rs_idx];
    assign rt_val = (wb_en && wb_reg == rt_idx) ? wb_data : regs[rt_idx];
    assign rd_val = (wb_en && wb_reg == rd_idx) ? wb_data : regs[rd_idx];

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        pc_ex      <= pc_id;
        rs_val_ex  <= rs_val;
        rt_val_ex  <= rt_val;
        rd_val_ex  <= rd_val;
        rs_ex      <= rs_idx;
        rt_ex      <= rt_idx;
        rd_ex      <= rd_idx;
        imm_ex     <= imm;
        alu_op_ex  <= alu_op;
        use_imm_ex <= use_imm;
    end

    // ID/EX control, bubble on stall or flush
    always_ff @(posedge clk)
    begin
        if (rst || stall || flush)
        begin
            br_kind_ex   <= BR_NONE;
            mem_read_ex  <= 1'b0;
            mem_write_ex <= 1'b0;
            reg_write_ex <= 1'b0;
        end
        else
        begin
            br_kind_ex   <= br_kind;
            mem_read_ex  <= mem_read;
            mem_write_ex <= mem_write;
            reg_write_ex <= reg_write;
        end
    end

endmodule

//--- execute_stage.sv
module execute_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] pc_ex,
    input  logic [WORD_W-1:0] rs_val_ex,
    input  logic [WORD_W-1:0] rt_val_ex,
    input  logic [WORD_W-1:0] rd_val_ex,
    input  logic [REG_W-1:0]  rd_ex,
    input  logic [WORD_W-1:0] imm_ex,
    input  alu_op_t           alu_op_ex,
    input  br_kind_t          br_kind_ex,
    input  logic              mem_read_ex,
    input  logic              mem_write_ex,
    input  logic              reg_write_ex,
    input  logic              use_imm_ex,
    input  fwd_sel_t          fwd_a,
    input  fwd_sel_t          fwd_b,
    input  fwd_sel_t          fwd_d,
    input  logic [WORD_W-1:0] wb_data,
    output logic              branch_taken,
    output logic [ADDR_W-1:0] branch_target,
    output logic [WORD_W-1:0] alu_mem,
    output logic [WORD_W-1:0] store_data_mem,
    output logic [REG_W-1:0]  rd_mem,
    output logic              mem_read_mem,
    output logic              mem_write_mem,
    output logic              reg_write_mem
);

    logic [WORD_W-1:0] op_a;
    logic [WORD_W-1:0] op_rt;
    logic [WORD_W-1:0] op_b;
    logic [WORD_W-1:0] op_d;
    logic [WORD_W-1:0] alu_y;

    function automatic logic [WORD_W-1:0] pick(
        input fwd_sel_t          sel,
        input logic [WORD_W-1:0] reg_val,
        input logic [WORD_W-1:0] mem_val,
        input logic [WORD_W-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Operand forwarding
    assign op_a  = pick(fwd_a, rs_val_ex, alu_mem, wb_data);
    assign op_rt = pick(fwd_b, rt_val_ex, alu_mem, wb_data);
    assign op_d  = pick(fwd_d, rd_val_ex, alu_mem, wb_data);
    assign op_b  = use_imm_ex ? imm_ex : op_rt;

    always_comb
    begin
        case (alu_op_ex)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_y = op_b;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch resolution on the forwarded rd

    always_comb
    begin
        case (br_kind_ex)
            BR_EQZ:    branch_taken = (op_d == '0);
            BR_NEZ:    branch_taken = (op_d != '0);
            BR_ALWAYS: branch_taken = 1'b1;
            default:   branch_taken = 1'b0;
        endcase
    end

    // Target wraps at the pc width
    assign branch_target = pc_ex + 1'b1 + imm_ex[ADDR_W-1:0];

    always_ff @(posedge clk)
    begin
        alu_mem        <= alu_y;
        store_data_mem <= op_d;
        rd_mem         <= rd_ex;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_read_mem  <= 1'b0;
            mem_write_mem <= 1'b0;
            reg_write_mem <= 1'b0;
        end
        else
        begin
            mem_read_mem  <= mem_read_ex;
            mem_write_mem <= mem_write_ex;
            reg_write_mem <= reg_write_ex;
        end
    end

endmodule

//--- memory_stage.sv
module memory_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] alu_mem,
    input  logic [WORD_W-1:0] store_data_mem,
    input  logic [REG_W-1:0]  rd_mem,
    input  logic              mem_read_mem,
    input  logic              mem_write_mem,
    input  logic              reg_write_mem,
    output logic              wb_en,
    output logic [REG_W-1:0]  wb_reg,
    output logic [WORD_W-1:0] wb_data
);

    logic [WORD_W-1:0] dmem [MEM_DEPTH];
    logic [WORD_W-1:0] load_word;

    // Address is the low byte of the ALU result
    always_ff @(posedge clk)
    begin
        if (mem_write_mem)
            dmem[alu_mem[ADDR_W-1:0]] <= store_data_mem;
    end

    assign load_word = dmem[alu_mem[ADDR_W-1:0]];

    //////////////////////////////////////////////////
    // MEM/WB

    always_ff @(posedge clk)
    begin
        wb_reg  <= rd_mem;
        wb_data <= mem_read_mem ? load_word : alu_mem;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wb_en <= 1'b0;
        else
            wb_en <= reg_write_mem;
    end

endmodule

//--- hazard_unit.sv
module hazard_unit import cpu_pkg::*; (
    input  logic             [REG_W-1:0] rs_idx,
    input  logic             [REG_W-1:0] rt_idx,
    input  logic             [REG_W-1:0] rd_idx_id,
    input  logic             [REG_W-1:0] rs_ex,
    input  logic             [REG_W-1:0] rt_ex,
    input  logic             [REG_W-1:0] rd_ex,
    input  logic                         mem_read_ex,
    input  logic             [REG_W-1:0] rd_mem,
    input  logic                         reg_write_mem,
    input  logic             [REG_W-1:0] wb_reg,
    input  logic                         wb_en,
    input  logic                         branch_taken,
    output logic                         stall,
    output logic                         flush,
    output fwd_sel_t                     fwd_a,
    output fwd_sel_t                     fwd_b,
    output fwd_sel_t                     fwd_d
);

    logic load_use;

    // Nearest producer first
    function automatic fwd_sel_t select_src(
        input logic [REG_W-1:0] src,
        input logic [REG_W-1:0] mem_dst,
        input logic             mem_we,
        input logic [REG_W-1:0] wb_dst,
        input logic             wb_we
    );
        if (mem_we && mem_dst == src)
            return FWD_MEM;
        else if (wb_we && wb_dst == src)
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    // Loaded word is not ready until it reaches MEM/WB
    assign load_use = mem_read_ex &&
                      (rd_ex == rs_idx || rd_ex == rt_idx || rd_ex == rd_idx_id);

    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

    assign fwd_a = select_src(rs_ex, rd_mem, reg_write_mem, wb_reg, wb_en);
    assign fwd_b = select_src(rt_ex, rd_mem, reg_write_mem, wb_reg, wb_en);
    assign fwd_d = select_src(rd_ex, rd_mem, reg_write_mem, wb_reg, wb_en);

endmodule

//--- pipeline.sv
module pipeline import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [WORD_W-1:0] prog_data,
    output logic              wb_en,
    output logic [REG_W-1:0]  wb_reg,
    output logic [WORD_W-1:0] wb_data
);

    // Fetch to decode
    logic [ADDR_W-1:0] pc_id;
    logic [WORD_W-1:0] instr_id;

    // Decode sources toward the hazard unit
    logic [REG_W-1:0]  rs_idx;
    logic [REG_W-1:0]  rt_idx;
    logic [REG_W-1:0]  rd_idx;

    // ID/EX
    logic [ADDR_W-1:0] pc_ex;
    logic [WORD_W-1:0] rs_val_ex;
    logic [WORD_W-1:0] rt_val_ex;
    logic [WORD_W-1:0] rd_val_ex;
    logic [REG_W-1:0]  rs_ex;
    logic [REG_W-1:0]  rt_ex;
    logic [REG_W-1:0]  rd_ex;
    logic [WORD_W-1:0] imm_ex;
    alu_op_t           alu_op_ex;
    br_kind_t          br_kind_ex;
    logic              mem_read_ex;
    logic              mem_write_ex;
    logic              reg_write_ex;
    logic              use_imm_ex;

    // EX/MEM
    logic [WORD_W-1:0] alu_mem;
    logic [WORD_W-1:0] store_data_mem;
    logic [REG_W-1:0]  rd_mem;
    logic              mem_read_mem;
    logic              mem_write_mem;
    logic              reg_write_mem;

    // Redirect and hazard control
    logic              branch_taken;
    logic [ADDR_W-1:0] branch_target;
    logic              stall;
    logic              flush;
    fwd_sel_t          fwd_a;
    fwd_sel_t          fwd_b;
    fwd_sel_t          fwd_d;

    //////////////////////////////////////////////////
    // Stages

    fetch_stage u_fetch (
        .clk           (clk),
        .rst           (rst),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .stall         (stall),
        .flush         (flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc_id         (pc_id),
        .instr_id      (instr_id)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .pc_id        (pc_id),
        .instr_id     (instr_id),
        .stall        (stall),
        .flush        (flush),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rd_idx       (rd_idx),
        .pc_ex        (pc_ex),
        .rs_val_ex    (rs_val_ex),
        .rt_val_ex    (rt_val_ex),
        .rd_val_ex    (rd_val_ex),
        .rs_ex        (rs_ex),
        .rt_ex        (rt_ex),
        .rd_ex        (rd_ex),
        .imm_ex       (imm_ex),
        .alu_op_ex    (alu_op_ex),
        .br_kind_ex   (br_kind_ex),
        .mem_read_ex  (mem_read_ex),
        .mem_write_ex (mem_write_ex),
        .reg_write_ex (reg_write_ex),
        .use_imm_ex   (use_imm_ex)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst            (rst),
        .pc_ex          (pc_ex),
        .rs_val_ex      (rs_val_ex),
        .rt_val_ex      (rt_val_ex),
        .rd_val_ex      (rd_val_ex),
        .rd_ex          (rd_ex),
        .imm_ex         (imm_ex),
        .alu_op_ex      (alu_op_ex),
        .br_kind_ex     (br_kind_ex),
        .mem_read_ex    (mem_read_ex),
        .mem_write_ex   (mem_write_ex),
        .reg_write_ex   (reg_write_ex),
        .use_imm_ex     (use_imm_ex),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .fwd_d          (fwd_d),
        .wb_data        (wb_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .alu_mem        (alu_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .reg_write_mem  (reg_write_mem)
    );

    memory_stage u_memory (
        .clk            (clk),
        .rst            (rst),
        .alu_mem        (alu_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .reg_write_mem  (reg_write_mem),
        .wb_en          (wb_en),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data)
    );

    hazard_unit u_hazard (
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .rd_idx_id     (rd_idx),
        .rs_ex         (rs_ex),
        .rt_ex         (rt_ex),
        .rd_ex         (rd_ex),
        .mem_read_ex   (mem_read_ex),
        .rd_mem        (rd_mem),
        .reg_write_mem (reg_write_mem),
        .wb_reg        (wb_reg),
        .wb_en         (wb_en),
        .branch_taken  (branch_taken),
        .stall         (stall),
        .flush         (flush),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd_d         (fwd_d)
    );

endmodule

//--- tb_pipeline.sv
module tb_pipeline import cpu_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              prog_we;
    logic [ADDR_W-1:0] prog_addr;
    logic [WORD_W-1:0] prog_data;
    logic              wb_en;
    logic [REG_W-1:0]  wb_reg;
    logic [WORD_W-1:0] wb_data;

    // Program image and the expected writeback sequence
    logic [WORD_W-1:0] prog_q [$];
    logic [REG_W-1:0]  exp_reg_q [$];
    logic [WORD_W-1:0] exp_val_q [$];
    logic [REG_W-1:0]  exp_reg;
    logic [WORD_W-1:0] exp_val;

    string cur_test;
    logic  active;
    int    wb_seen;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;
    int    run_cycles;
    int    budget = 50;
    int    seed = 6244;

    pipeline u_dut (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Instruction encoders

    function automatic logic [WORD_W-1:0] r_type(opcode_t op, int rd, int rs, int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    function automatic logic [WORD_W-1:0] i_type(opcode_t op, int rd, int rs, int imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    function automatic logic [WORD_W-1:0] li_word(int rd, int imm);
        return {OP_LI, 3'(rd), 1'b0, 8'(imm)};
    endfunction

    function automatic logic [WORD_W-1:0] branch_word(opcode_t op, int rd, int off);
        return {op, 3'(rd), 9'(off)};
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    //////////////////////////////////////////////////
    // Instruction-level model of the ISA

    function automatic int run_model();
        logic [WORD_W-1:0] r [NUM_REGS];
        logic [WORD_W-1:0] dm [MEM_DEPTH];
        logic [WORD_W-1:0] w;
        logic [WORD_W-1:0] s6;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] val;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] next_pc;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic              wr;
        opcode_t           op;
        int                steps;
        exp_reg_q.delete();
        exp_val_q.delete();
        for (int i = 0; i < NUM_REGS; i++)
            r[i] = '0;
        for (int i = 0; i < MEM_DEPTH; i++)
            dm[i] = 'x;
        pc = '0;
        for (steps = 0; steps < 1000; steps++)
        begin
            w       = prog_q[pc];
            op      = opcode_t'(w[15:12]);
            rd      = w[11:9];
            rs      = w[8:6];
            rt      = w[5:3];
            s6      = {{10{w[5]}}, w[5:0]};
            addr    = r[rs] + s6;
            next_pc = pc + 8'd1;
            wr      = 1'b1;
            val     = '0;
            case (op)
                OP_ADD:  val = r[rs] + r[rt];
                OP_SUB:  val = r[rs] - r[rt];
                OP_AND:  val = r[rs] & r[rt];
                OP_OR:   val = r[rs] | r[rt];
                OP_SLT:  val = ($signed(r[rs]) < $signed(r[rt])) ? 16'd1 : 16'd0;
                OP_ADDI: val = addr;
                OP_LI:   val = {8'd0, w[7:0]};
                OP_LW:   val = dm[addr[7:0]];
                default: wr = 1'b0;
            endcase
            if (op == OP_SW)
                dm[addr[7:0]] = r[rd];
            // Offset wraps with the 8-bit pc
            if ((op == OP_BEQZ && r[rd] == '0) || (op == OP_BNEZ && r[rd] != '0) || op == OP_B)
                next_pc = pc + 8'd1 + w[7:0];
            if (wr)
            begin
                r[rd] = val;
                exp_reg_q.push_back(rd);
                exp_val_q.push_back(val);
            end
            // Jump to self closes the program
            if (op == OP_B && next_pc == pc)
                break;
            pc = next_pc;
        end
        return exp_reg_q.size();
    endfunction

    //////////////////////////////////////////////////
    // Program builders

    task automatic build_alu_chain();
        prog_q.delete();
        prog_q.push_back(li_word(1, 5));
        prog_q.push_back(li_word(2, 3));
        // r1 from MEM/WB, r2 from EX/MEM
        prog_q.push_back(r_type(OP_ADD, 3, 1, 2));
        prog_q.push_back(r_type(OP_SUB, 4, 3, 1));
        prog_q.push_back(r_type(OP_AND, 5, 4, 3));
        prog_q.push_back(r_type(OP_OR, 6, 5, 4));
        prog_q.push_back(r_type(OP_SLT, 7, 4, 6));
        prog_q.push_back(i_type(OP_ADDI, 0, 7, -2));
        prog_q.push_back(r_type(OP_SLT, 1, 0, 7));
        prog_q.push_back(li_word(2, 200));
        prog_q.push_back(r_type(OP_ADD, 3, 2, 2));
        prog_q.push_back(r_type(OP_SUB, 4, 0, 3));
        prog_q.push_back(branch_word(OP_B, 0, -1));
    endtask

    task automatic build_load_use();
        prog_q.delete();
        prog_q.push_back(li_word(1, 10));
        prog_q.push_back(li_word(2, 77));
        prog_q.push_back(i_type(OP_SW, 2, 1, 3));
        prog_q.push_back(i_type(OP_LW, 3, 1, 3));
        prog_q.push_back(r_type(OP_ADD, 4, 3, 2));
        prog_q.push_back(i_type(OP_LW, 5, 1, 3));
        prog_q.push_back(i_type(OP_ADDI, 6, 5, 1));
        // Store data and branch condition straight after a load
        prog_q.push_back(i_type(OP_LW, 7, 1, 3));
        prog_q.push_back(i_type(OP_SW, 7, 1, 4));
        prog_q.push_back(i_type(OP_LW, 0, 1, 4));
        prog_q.push_back(branch_word(OP_BNEZ, 0, 1));
        prog_q.push_back(li_word(1, 1));
        prog_q.push_back(r_type(OP_ADD, 2, 0, 0));
        prog_q.push_back(branch_word(OP_B, 0, -1));
    endtask

    task automatic build_store_load();
        prog_q.delete();
        prog_q.push_back(li_word(1, 40));
        prog_q.push_back(r_type(OP_ADD, 2, 1, 1));
        prog_q.push_back(i_type(OP_SW, 2, 1, 0));
        prog_q.push_back(li_word(7, 2));
        // Address 253 after the wrap
        prog_q.push_back(i_type(OP_SW, 1, 7, -5));
        prog_q.push_back(i_type(OP_ADDI, 3, 1, -1));
        prog_q.push_back(i_type(OP_SW, 3, 1, 5));
        prog_q.push_back(i_type(OP_LW, 4, 1, 0));
        prog_q.push_back(i_type(OP_LW, 5, 1, 5));
        prog_q.push_back(i_type(OP_LW, 6, 7, -5));
        prog_q.push_back(r_type(OP_SUB, 0, 4, 5));
        prog_q.push_back(branch_word(OP_B, 0, -1));
    endtask

    task automatic build_branches();
        prog_q.delete();
        prog_q.push_back(li_word(1, 0));
        prog_q.push_back(branch_word(OP_BEQZ, 1, 2));
        prog_q.push_back(li_word(2, 11));
        prog_q.push_back(li_word(3, 12));
        prog_q.push_back(li_word(4, 1));
        prog_q.push_back(branch_word(OP_BNEZ, 4, 1));
        prog_q.push_back(li_word(5, 99));
        prog_q.push_back(branch_word(OP_BEQZ, 4, 1));
        prog_q.push_back(li_word(6, 6));
        prog_q.push_back(branch_word(OP_BNEZ, 1, 1));
        prog_q.push_back(li_word(7, 7));
        prog_q.push_back(branch_word(OP_B, 0, 1));
        prog_q.push_back(li_word(0, 55));
        prog_q.push_back(i_type(OP_ADDI, 1, 4, 2));
        prog_q.push_back(branch_word(OP_B, 0, -1));
    endtask

    task automatic append_random_alu();
        int kind;
        int rd;
        int rs;
        int rt;
        kind = rand_below(7);
        rd   = rand_below(8);
        rs   = rand_below(8);
        rt   = rand_below(8);
        case (kind)
            0:       prog_q.push_back(r_type(OP_ADD, rd, rs, rt));
            1:       prog_q.push_back(r_type(OP_SUB, rd, rs, rt));
            2:       prog_q.push_back(r_type(OP_AND, rd, rs, rt));
            3:       prog_q.push_back(r_type(OP_OR, rd, rs, rt));
            4:       prog_q.push_back(r_type(OP_SLT, rd, rs, rt));
            5:       prog_q.push_back(i_type(OP_ADDI, rd, rs, rand_below(64) - 32));
            default: prog_q.push_back(li_word(rd, rand_below(256)));
        endcase
    endtask

    // 39 random instructions, then the closing loop
    task automatic build_random();
        logic [ADDR_W-1:0] stored [$];
        int                kind;
        int                k;
        int                ra;
        int                off;
        int                base;
        prog_q.delete();
        while (prog_q.size() < 39)
        begin
            kind = rand_below(10);
            ra   = rand_below(8);
            off  = rand_below(64) - 32;
            if (kind < 4 || prog_q.size() > 36 || (kind < 8 && kind >= 6 && stored.size() == 0))
                append_random_alu();
            else if (kind < 6)
            begin
                base = rand_below(256);
                prog_q.push_back(li_word(ra, base));
                prog_q.push_back(i_type(OP_SW, rand_below(8), ra, off));
                stored.push_back(8'(base + off));
            end
            else if (kind < 8)
            begin
                base = int'(stored[rand_below(stored.size())]) - off;
                prog_q.push_back(li_word(ra, base));
                prog_q.push_back(i_type(OP_LW, rand_below(8), ra, off));
            end
            else
            begin
                // Forward branch over ALU ops only
                k = 1 + rand_below(3);
                if (prog_q.size() + 1 + k > 39)
                    k = 38 - prog_q.size();
                case (rand_below(3))
                    0:       prog_q.push_back(branch_word(OP_BEQZ, ra, k));
                    1:       prog_q.push_back(branch_word(OP_BNEZ, ra, k));
                    default: prog_q.push_back(branch_word(OP_B, 0, k));
                endcase
                repeat (k) append_random_alu();
            end
        end
        prog_q.push_back(branch_word(OP_B, 0, -1));
    endtask

    //////////////////////////////////////////////////
    // Test sequencing

    task automatic run_test(input string name);
        int n;
        cur_test    = name;
        n           = run_model();
        budget     += 3 * prog_q.size();
        test_errors = 0;
        wb_seen     = 0;
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < prog_q.size(); i++)
        begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = prog_q[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (4) @(negedge clk);
        active = 1'b1;
        rst    = 1'b0;
        wait (wb_seen == n);
        // Trailing cycles catch writebacks past the last expected one
        repeat (8) @(negedge clk);
        active = 1'b0;
        tests_run++;
        if (test_errors == 0)
            $display("[PASS] %s: %0d writebacks", name, n);
        else
        begin
            tests_failed++;
            $display("[FAIL] %s: %0d errors", name, test_errors);
        end
    endtask

    // Writeback compare against the model queue
    always @(posedge clk)
    begin
        if (active && wb_en)
        begin
            assert (exp_reg_q.size() > 0)
            else
            begin
                $display("%s: writeback to r%0d after the last expected one", cur_test, wb_reg);
                test_errors++;
                total_errors++;
            end
            if (exp_reg_q.size() > 0)
            begin
                exp_reg = exp_reg_q.pop_front();
                exp_val = exp_val_q.pop_front();
                assert (wb_reg == exp_reg)
                else
                begin
                    $display("[ERROR] %s: wb_reg expected %0d actual %0d",
                             cur_test, exp_reg, wb_reg);
                    test_errors++;
                    total_errors++;
                end
                assert (wb_data == exp_val)
                else
                begin
                    $display("[ERROR] %s: wb_data expected 0x%04h actual 0x%04h",
                             cur_test, exp_val, wb_data);
                    test_errors++;
                    total_errors++;
                end
                wb_seen++;
            end
        end
    end

    // Watchdog, budget grows as each test starts
    initial
    begin
        run_cycles = 0;
        while (run_cycles <= budget)
        begin
            @(posedge clk);
            if (!rst)
                run_cycles++;
        end
        $display("%s: timed out waiting for writebacks", cur_test);
        $display("test failed");
        $finish;
    end

    initial
    begin
        rst          = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        active       = 1'b0;
        wb_seen      = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_alu_chain();
        run_test("alu_forwarding");
        build_load_use();
        run_test("load_use");
        build_store_load();
        run_test("store_load");
        build_branches();
        run_test("branches");
        for (int t = 0; t < 3; t++)
        begin
            build_random();
            run_test($sformatf("random_%0d", t));
        end
        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- filelist.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
pipeline.sv
tb_pipeline.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_pipeline -f filelist.f -o sim_pipeline
	./obj_dir/sim_pipeline | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
